/* Makefile */
SRCS := $(shell cat src.f)
BIN  := obj_dir/Vafifo_bridge_tb

.PHONY: run clean

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

$(BIN): $(SRCS) src.f
	verilator --binary --assert -j 0 --top-module afifo_bridge_tb -f src.f \
		-o Vafifo_bridge_tb

clean:
	rm -rf obj_dir

/* sim/afifo_bridge_tb.sv */
module afifo_bridge_tb;

    localparam int W           = 16;
    localparam int N           = 4;
    localparam int DEPTH       = 1 << N;
    localparam int SEED        = 32'h0975_70d9;
    localparam int TOTAL_WORDS = 200 + DEPTH + 12;        // Transfer, fill and alert phases
    localparam int TIMEOUT     = TOTAL_WORDS * 100 * 20;  // Slower period times margin

    logic                        r_clk;
    logic                        w_clk;
    logic                        rst_;
    logic                        w_trigger;
    logic [W-1:0]                w_data;
    logic                        w_ready;
    logic                        r_trigger;
    logic [W-1:0]                r_data;
    logic                        r_ready;
    afifo_pkg::cfg_req_t         cfg;
    logic [afifo_pkg::REG_W-1:0] cfg_rdata;
    logic                        level_alert;

    logic [W-1:0] model [$];    // Words accepted but not yet popped
    int           w_seed = SEED;
    int           r_seed = SEED ^ 32'h0000_ffff;  // Separate stream for read gaps
    int           errors = 0;
    int           checks = 0;
    int           pops = 0;      // Pops seen since reset
    int           accepted = 0;  // Writes seen since reset
    logic         hold_low = 1'b0;  // r_ready must stay low
    string        test_name = "reset";

    tb_clock #(.HALF(50)) u_r_clock (.clk(r_clk));
    tb_clock #(.HALF(35)) u_w_clock (.clk(w_clk));  // Unrelated to r_clk

    afifo_bridge #(.W(W), .N(N)) u_afifo_bridge (
        .w_clk(w_clk), .w_trigger(w_trigger), .w_data(w_data), .w_ready(w_ready),
        .r_clk(r_clk), .r_trigger(r_trigger), .r_data(r_data), .r_ready(r_ready),
        .rst_(rst_), .cfg(cfg), .cfg_rdata(cfg_rdata), .level_alert(level_alert)
    );

    // ====================
    // Reference model
    // ====================
    function automatic logic [W-1:0] next_expected();
        return model.pop_front();  // Oldest accepted word
    endfunction

    // Alert is on at or above a non-zero threshold
    function automatic int alert_expected(input int level, input int thresh);
        return (thresh != 0 && level >= thresh) ? 1 : 0;
    endfunction

    task automatic check_value(input string what, input int exp, input int act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("[FAIL] %s %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    // ====================
    // Register strobes
    // ====================
    task automatic write_reg(input afifo_pkg::cfg_addr_e addr, input int data);
        @(negedge r_clk);
        cfg.we    = 1'b1;
        cfg.addr  = addr;
        cfg.wdata = data[afifo_pkg::REG_W-1:0];
        @(negedge r_clk);
        cfg.we    = 1'b0;  // Taken on the edge between
    endtask

    task automatic read_reg(input afifo_pkg::cfg_addr_e addr,
                            output logic [afifo_pkg::REG_W-1:0] data);
        @(negedge r_clk);
        cfg.re   = 1'b1;
        cfg.addr = addr;
        @(negedge r_clk);
        cfg.re   = 1'b0;
        data     = cfg_rdata;  // Registered on the edge between
    endtask

    // ====================
    // Producer and consumer
    // ====================
    task automatic write_words(input int n);
        int gap;
        for (int i = 0; i < n; i++) begin
            @(negedge w_clk);
            w_trigger = 1'b0;
            gap = $unsigned($random(w_seed)) % 4;
            repeat (gap) @(negedge w_clk);
            w_trigger = 1'b1;
            w_data    = W'($random(w_seed));
            while (!w_ready) @(negedge w_clk);  // Accepted on the next rising edge
        end
        @(negedge w_clk);
        w_trigger = 1'b0;
    endtask

    task automatic pop_words(input int n);
        int target;
        target = pops + n;
        while (pops < target) begin
            @(negedge r_clk);
            r_trigger = r_ready && (pops < target) && ($random(r_seed) % 3 != 0);
        end
    endtask

    // Model push on every accepted write
    always @(posedge w_clk) begin
        if (rst_ && w_trigger && w_ready) begin
            model.push_back(w_data);
            accepted++;
        end
    end

    // Compare every pop against the model
    always @(posedge r_clk) begin
        if (rst_ && r_trigger && r_ready) begin
            pops++;
            assert (model.size() > 0) else begin
                errors++;
                $display("A word was popped while the model queue was empty in %s", test_name);
            end
            if (model.size() > 0) begin
                check_value("pop data", int'(next_expected()), int'(r_data));
            end
        end
        if (rst_ && hold_low) begin
            assert (!r_ready) else begin
                errors++;
                $display("r_ready went high with drain disabled in %s", test_name);
            end
        end
    end

    // ====================
    // Test sequence
    // ====================
    initial begin
        logic [afifo_pkg::REG_W-1:0] rd;
        int base;
        int tries;
        rst_      = 1'b0;
        w_trigger = 1'b0;
        w_data    = '0;
        r_trigger = 1'b0;
        cfg       = '0;
        repeat (3) @(posedge r_clk);
        @(negedge r_clk);
        rst_ = 1'b1;

        // Reset state
        check_value("w_ready", 1, int'(w_ready));
        check_value("r_ready", 0, int'(r_ready));
        check_value("level_alert", 0, int'(level_alert));
        read_reg(afifo_pkg::CFG_CTRL, rd);
        check_value("ctrl", 1, int'(rd));
        read_reg(afifo_pkg::CFG_THRESH, rd);
        check_value("thresh", 0, int'(rd));
        read_reg(afifo_pkg::CFG_COUNT, rd);
        check_value("count", 0, int'(rd));

        test_name = "ordered_transfer";
        fork
            write_words(200);
            pop_words(200);
        join
        check_value("words left", 0, model.size());

        // Fill with the consumer blocked
        test_name = "full_backpressure";
        write_reg(afifo_pkg::CFG_CTRL, 0);
        hold_low = 1'b1;
        @(negedge w_clk);
        while (!w_ready) @(negedge w_clk);
        base = accepted;
        w_trigger = 1'b1;
        w_data    = W'($random(w_seed));
        @(negedge w_clk);
        while (w_ready) begin
            w_data = W'($random(w_seed));  // Previous word taken
            @(negedge w_clk);
        end
        w_trigger = 1'b0;
        repeat (8) @(negedge w_clk);  // Nothing more may slip in
        check_value("accepted", DEPTH, accepted - base);
        tries = 0;
        do begin
            read_reg(afifo_pkg::CFG_LEVEL, rd);
            tries++;
        end while (int'(rd) != DEPTH && tries < 8);
        check_value("level", DEPTH, int'(rd));

        test_name = "drain";
        write_reg(afifo_pkg::CFG_COUNT, 0);  // Counter restarts here
        base = pops;
        hold_low = 1'b0;
        write_reg(afifo_pkg::CFG_CTRL, 1);
        pop_words(DEPTH);
        check_value("r_ready", 0, int'(r_ready));
        check_value("words left", 0, model.size());
        repeat (4) @(negedge w_clk);  // Pointer sync plus two-stage release
        check_value("w_ready", 1, int'(w_ready));

        test_name = "pop_counter";
        repeat (2) @(negedge r_clk);  // Pulse plus counter edge
        read_reg(afifo_pkg::CFG_COUNT, rd);
        check_value("count", pops - base, int'(rd));
        write_reg(afifo_pkg::CFG_COUNT, 0);
        read_reg(afifo_pkg::CFG_COUNT, rd);
        check_value("count cleared", 0, int'(rd));

        // Alert follows each read-back level
        test_name = "threshold_alert";
        write_reg(afifo_pkg::CFG_THRESH, 8);
        write_reg(afifo_pkg::CFG_CTRL, 0);
        hold_low = 1'b1;
        for (int i = 0; i < 12; i++) begin
            write_words(1);
            read_reg(afifo_pkg::CFG_LEVEL, rd);
            check_value("alert", alert_expected(int'(rd), 8), int'(level_alert));
        end
        tries = 0;
        do begin
            read_reg(afifo_pkg::CFG_LEVEL, rd);
            check_value("alert", alert_expected(int'(rd), 8), int'(level_alert));
            tries++;
        end while (int'(rd) != 12 && tries < 8);
        check_value("final alert", 1, int'(level_alert));
        write_reg(afifo_pkg::CFG_THRESH, 0);
        hold_low = 1'b0;
        write_reg(afifo_pkg::CFG_CTRL, 1);
        pop_words(12);
        check_value("r_ready", 0, int'(r_ready));
        check_value("words left", 0, model.size());

        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT);
        $display("Watchdog expired in %s before the tests finished", test_name);
        $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
module tb_clock #(
    parameter int HALF = 50  // Half period in time units
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(HALF) clk = ~clk;
        end
    end

endmodule

/* src.f */
src/afifo_pkg.sv
src/afifo_mem.sv
src/afifo_wr_ctrl.sv
src/afifo_rd_ctrl.sv
src/afifo_cfg_regs.sv
src/afifo_bridge.sv
sim/tb_clock.sv
sim/afifo_bridge_tb.sv

/* src/afifo_bridge.sv */
module afifo_bridge #(
    parameter int W = 16,  // Word width
    parameter int N = 4    // Address bits, 2^N words
) (
    // Producer side
    input  logic                         w_clk,
    input  logic                         w_trigger,
    input  logic [W-1:0]                 w_data,
    output logic                         w_ready,
    // Consumer side
    input  logic                         r_clk,
    input  logic                         r_trigger,
    output logic [W-1:0]                 r_data,
    output logic                         r_ready,
    // Shared reset and register port
    input  logic                         rst_,
    input  afifo_pkg::cfg_req_t          cfg,
    output logic [afifo_pkg::REG_W-1:0]  cfg_rdata,
    output logic                         level_alert
);

    logic                  we;         // Memory write enable
    logic [N-1:0]          waddr;
    logic [N-1:0]          raddr;
    logic [N:0]            w_gptr;     // Crosses into r_clk
    logic [N:0]            r_gptr;     // Crosses into w_clk
    logic                  drain_en;
    afifo_pkg::rd_status_t rd_status;

    // ====================
    // Datapath
    // ====================
    afifo_mem #(.W(W), .N(N)) u_mem (
        .w_clk (w_clk),
        .we    (we),
        .waddr (waddr),
        .wdata (w_data),
        .raddr (raddr),
        .rdata (r_data)   // Valid while r_ready is high
    );

    // ====================
    // Control
    // ====================
    afifo_wr_ctrl #(.N(N)) u_wr_ctrl (
        .w_clk     (w_clk),
        .rst_      (rst_),
        .w_trigger (w_trigger),
        .r_gptr    (r_gptr),
        .w_ready   (w_ready),
        .we        (we),
        .waddr     (waddr),
        .w_gptr    (w_gptr)
    );

    afifo_rd_ctrl #(.N(N)) u_rd_ctrl (
        .r_clk     (r_clk),
        .rst_      (rst_),
        .r_trigger (r_trigger),
        .drain_en  (drain_en),
        .w_gptr    (w_gptr),
        .r_ready   (r_ready),
        .raddr     (raddr),
        .r_gptr    (r_gptr),
        .rd_status (rd_status)
    );

    afifo_cfg_regs u_cfg_regs (
        .r_clk       (r_clk),
        .rst_        (rst_),
        .cfg         (cfg),
        .cfg_rdata   (cfg_rdata),
        .rd_status   (rd_status),
        .drain_en    (drain_en),
        .level_alert (level_alert)
    );

endmodule

/* src/afifo_cfg_regs.sv */
module afifo_cfg_regs (
    input  logic                         r_clk,
    input  logic                         rst_,
    input  afifo_pkg::cfg_req_t          cfg,
    output logic [afifo_pkg::REG_W-1:0]  cfg_rdata,
    input  afifo_pkg::rd_status_t        rd_status,
    output logic                         drain_en,
    output logic                         level_alert
);

    logic                        drain_q;   // CFG_CTRL bit 0
    logic [afifo_pkg::REG_W-1:0] thresh_q;  // CFG_THRESH
    logic [afifo_pkg::REG_W-1:0] count_q;   // CFG_COUNT
    logic [afifo_pkg::REG_W-1:0] rd_mux;    // Selected read word

    assign drain_en = drain_q;

    // ====================
    // Writable registers
    // ====================
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            drain_q  <= 1'b1;  // Drain on by default
            thresh_q <= '0;    // Alert off
        end else if (cfg.we) begin
            case (cfg.addr)
                afifo_pkg::CFG_CTRL:   drain_q  <= cfg.wdata[afifo_pkg::CTRL_DRAIN_BIT];
                afifo_pkg::CFG_THRESH: thresh_q <= cfg.wdata;
                default: ;             // Level is read only, count handled below
            endcase
        end
    end

    // Saturating pop counter, any write clears it
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            count_q <= '0;
        end else if (cfg.we && (cfg.addr == afifo_pkg::CFG_COUNT)) begin
            count_q <= '0;
        end else if (rd_status.pop && (count_q != '1)) begin
            count_q <= count_q + 1'b1;
        end
    end

    // ====================
    // Read port
    // ====================
    always_comb begin
        rd_mux = '0;
        case (cfg.addr)
            afifo_pkg::CFG_CTRL:   rd_mux[afifo_pkg::CTRL_DRAIN_BIT] = drain_q;
            afifo_pkg::CFG_THRESH: rd_mux = thresh_q;
            afifo_pkg::CFG_LEVEL:  rd_mux = rd_status.level;
            afifo_pkg::CFG_COUNT:  rd_mux = count_q;
            default:               rd_mux = '0;
        endcase
    end

    // Held until the next read strobe
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            cfg_rdata <= '0;
        end else if (cfg.re) begin
            cfg_rdata <= rd_mux;
        end
    end

    // Alert trails the level by one cycle, zero threshold disables it
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            level_alert <= 1'b0;
        end else begin
            level_alert <= (thresh_q != '0) && (rd_status.level >= thresh_q);
        end
    end

    // Strobes are exclusive on the register port
    a_we_re_excl: assert property (@(posedge r_clk) disable iff (!rst_)
        !(cfg.we && cfg.re));

endmodule

/* src/afifo_mem.sv */
module afifo_mem #(
    parameter int W = 16,  // Word width
    parameter int N = 4    // Address bits
) (
    input  logic         w_clk,
    input  logic         we,
    input  logic [N-1:0] waddr,
    input  logic [W-1:0] wdata,
    input  logic [N-1:0] raddr,
    output logic [W-1:0] rdata
);

    // 2^N words, no reset so the array maps onto distributed RAM
    logic [W-1:0] mem [0:(1<<N)-1];

    // Write port in the producer domain
    always_ff @(posedge w_clk) begin
        if (we) begin
            mem[waddr] <= wdata;  // Slot owned by the writer until the pointer moves
        end
    end

    // Unclocked read port
    // Slot under raddr is stable whenever the FIFO is not empty
    assign rdata = mem[raddr];

endmodule

/* src/afifo_pkg.sv */
package afifo_pkg;

    // ====================
    // Register map
    // ====================
    localparam int REG_W          = 16;  // Width of every config register
    localparam int CTRL_DRAIN_BIT = 0;   // Drain enable position in CFG_CTRL

    typedef enum logic [1:0] {
        CFG_CTRL   = 2'd0,  // Control, bit 0 drain enable
        CFG_THRESH = 2'd1,  // Fill level alert threshold
        CFG_LEVEL  = 2'd2,  // Read-side fill level, read only
        CFG_COUNT  = 2'd3   // Pop counter, cleared by any write
    } cfg_addr_e;

    // ====================
    // Shared structs
    // ====================
    // Register strobe from the outside world
    typedef struct packed {
        logic             we;     // Write strobe
        logic             re;     // Read strobe
        cfg_addr_e        addr;   // Register select
        logic [REG_W-1:0] wdata;  // Write data
    } cfg_req_t;

    // Read controller status toward the register block
    typedef struct packed {
        logic [REG_W-1:0] level;  // Registered fill level
        logic             pop;    // One cycle per word popped
    } rd_status_t;

endpackage

/* src/afifo_rd_ctrl.sv */
module afifo_rd_ctrl #(
    parameter int N = 4  // Address bits
) (
    input  logic                    r_clk,
    input  logic                    rst_,
    input  logic                    r_trigger,
    input  logic                    drain_en,   // From CFG_CTRL
    input  logic [N:0]              w_gptr,     // Gray write pointer from w_clk domain
    output logic                    r_ready,
    output logic [N-1:0]            raddr,
    output logic [N:0]              r_gptr,     // Gray read pointer toward w_clk domain
    output afifo_pkg::rd_status_t   rd_status
);

    // Largest legal fill level
    localparam logic [afifo_pkg::REG_W-1:0] DEPTH = 1 << N;

    logic [N:0] r_bptr;      // Binary read pointer
    logic [N:0] r_bptr_nxt;
    logic [N:0] w_gptr_s1;   // First sync stage
    logic [N:0] w_gptr_s2;   // Second sync stage
    logic [N:0] w_bsync;     // Synced write pointer in binary
    logic [N:0] fill;        // Words held, 0 to 2^N
    logic       empty;
    logic       pop;

    // ====================
    // Read pointer
    // ====================
    assign empty      = (r_gptr == w_gptr_s2);
    assign r_ready    = ~empty & drain_en;       // Drain enable gates the consumer
    assign pop        = r_trigger & r_ready;
    assign raddr      = r_bptr[N-1:0];
    assign r_bptr_nxt = pop ? r_bptr + 1'b1 : r_bptr;

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            r_bptr <= '0;
            r_gptr <= '0;
        end else begin
            r_bptr <= r_bptr_nxt;
            r_gptr <= (r_bptr_nxt >> 1) ^ r_bptr_nxt;  // Binary to Gray
        end
    end

    // Write pointer into r_clk, two flops
    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            w_gptr_s1 <= '0;
            w_gptr_s2 <= '0;
        end else begin
            w_gptr_s1 <= w_gptr;
            w_gptr_s2 <= w_gptr_s1;
        end
    end

    // ====================
    // Fill level
    // ====================
    // Gray to binary, each bit is the XOR of itself and all above
    always_comb begin
        for (int i = 0; i <= N; i++) begin
            w_bsync[i] = ^(w_gptr_s2 >> i);
        end
    end

    assign fill = w_bsync - r_bptr;  // Wraps cleanly in N+1 bits

    always_ff @(posedge r_clk or negedge rst_) begin
        if (!rst_) begin
            rd_status <= '0;
        end else begin
            rd_status.level <= afifo_pkg::REG_W'(fill);
            rd_status.pop   <= pop;  // Seen by the counter one edge later
        end
    end

    // Depth must leave room in REG_W for the level
    a_n_range: assert property (@(posedge r_clk) (N >= 2) && (N <= 15));

    a_level_max: assert property (@(posedge r_clk) disable iff (!rst_)
        rd_status.level <= DEPTH);

    // A pop always takes a word that the binary fill level counts
    a_pop_ready: assert property (@(posedge r_clk) disable iff (!rst_)
        pop |-> (fill != '0));

endmodule

/* src/afifo_wr_ctrl.sv */
module afifo_wr_ctrl #(
    parameter int N = 4  // Address bits
) (
    input  logic         w_clk,
    input  logic         rst_,
    input  logic         w_trigger,
    input  logic [N:0]   r_gptr,   // Gray read pointer from r_clk domain
    output logic         w_ready,
    output logic         we,
    output logic [N-1:0] waddr,
    output logic [N:0]   w_gptr    // Gray write pointer toward r_clk domain
);

    logic [N:0] w_bptr;      // Binary write pointer
    logic [N:0] w_bptr_nxt;
    logic [N:0] w_gptr_nxt;
    logic [N:0] r_gptr_s1;   // First sync stage
    logic [N:0] r_gptr_s2;   // Second sync stage
    logic [1:0] rdy_n;       // Inverted ready pipe
    logic       full;        // Current pointer state is full
    logic       full_nxt;    // Pointer state after this edge is full

    // ====================
    // Write pointer
    // ====================
    assign we         = w_trigger & w_ready;         // Accepted word
    assign waddr      = w_bptr[N-1:0];
    assign w_bptr_nxt = we ? w_bptr + 1'b1 : w_bptr;
    assign w_gptr_nxt = (w_bptr_nxt >> 1) ^ w_bptr_nxt;  // Binary to Gray

    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            w_bptr <= '0;
            w_gptr <= '0;
        end else begin
            w_bptr <= w_bptr_nxt;
            w_gptr <= w_gptr_nxt;
        end
    end

    // Read pointer into w_clk, two flops
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            r_gptr_s1 <= '0;
            r_gptr_s2 <= '0;
        end else begin
            r_gptr_s1 <= r_gptr;
            r_gptr_s2 <= r_gptr_s1;
        end
    end

    // ====================
    // Full and ready
    // ====================
    // Full when the top two Gray bits differ and the rest match
    assign full     = (w_gptr == {~r_gptr_s2[N:N-1], r_gptr_s2[N-2:0]});
    assign full_nxt = (w_gptr_nxt == {~r_gptr_s1[N:N-1], r_gptr_s1[N-2:0]});

    // Inverted pipe clears on reset so the port starts out ready
    always_ff @(posedge w_clk or negedge rst_) begin
        if (!rst_) begin
            rdy_n <= 2'b00;
        end else if (full_nxt) begin
            rdy_n <= 2'b11;              // Block on the edge that fills the FIFO
        end else begin
            rdy_n <= {rdy_n[0], 1'b0};   // Two edges to release
        end
    end

    assign w_ready = ~rdy_n[1];

    // Ready pipe must cover every full state
    a_no_write_full: assert property (@(posedge w_clk) disable iff (!rst_)
        full |-> !we);

endmodule
